// ==== mul_pkg.sv ====
`default_nettype none

package mul_pkg;

  // Width of each multiplier operand
  localparam int MUL_SIZE = 32;

  // The full product and the final adder are twice the operand width
  localparam int PROD_SIZE = 2 * MUL_SIZE;

  // Radix-4 Booth looks at overlapping 3-bit windows of the multiplier,
  // so a 32-bit multiplier with two sign bits on top needs 17 windows
  localparam int OP_NUM = MUL_SIZE / 2 + 1;

  // Two more rows carry the +1 terms of the negated partial products
  localparam int PP_NUM = OP_NUM + 2;

  // Enough bits to count up to OP_NUM negative windows
  localparam int NEG_CNT_WIDTH = $clog2(MUL_SIZE);

  // Operations supported by the unit
  typedef enum logic [1:0] {
    OP_MUL    = 2'b00,
    OP_MULH   = 2'b01,
    OP_MULHSU = 2'b10,
    OP_MULHU  = 2'b11
  } mul_op_e;

  // Selection made by one Booth window
  typedef enum logic [2:0] {
    BOOTH_ZERO = 3'd0,
    BOOTH_POS1 = 3'd1,
    BOOTH_POS2 = 3'd2,
    BOOTH_NEG2 = 3'd3,
    BOOTH_NEG1 = 3'd4
  } booth_sel_e;

endpackage

`default_nettype wire

// ==== flow_pkg.sv ====
`default_nettype none

package flow_pkg;

  import mul_pkg::*;

  // Width of the request tag that is echoed back with the result
  localparam int TAG_WIDTH = 4;

  // Response FIFO depth, which is also the producer's credit pool after reset
  localparam int BUF_DEPTH = 4;

  // Credits the consumer grants to the unit after reset
  localparam int RESP_CREDITS = 2;

  // Wide enough to hold either credit pool
  localparam int CREDIT_WIDTH = 3;

  // One multiply request as it crosses the upstream interface
  typedef struct packed {
    mul_op_e                op;
    logic [TAG_WIDTH-1:0]   tag;
    logic [MUL_SIZE-1:0]    op1;
    logic [MUL_SIZE-1:0]    op2;
  } mul_req_t;

  // One result as it crosses the downstream interface
  typedef struct packed {
    logic [TAG_WIDTH-1:0]   tag;
    logic [MUL_SIZE-1:0]    result;
  } mul_resp_t;

endpackage

`default_nettype wire

// ==== op_n_to_2_nbit.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_n_to_2_nbit #(
  parameter int OP_NUM   = 3,
  parameter int OP_WIDTH = 8
) (
  input  logic [OP_WIDTH-1:0] in_op  [OP_NUM],
  output logic [OP_WIDTH-1:0] out_op [2]
);

  // Row count left after a given number of 3:2 layers
  function automatic int rows_after(input int n, input int layers);
    int r;
    r = n;
    for (int k = 0; k < layers; k++) begin
      if (r > 2) r = 2 * (r / 3) + r % 3;
    end
    return r;
  endfunction

  // Number of layers needed to reach two rows
  function automatic int layer_count(input int n);
    int r;
    int l;
    r = n;
    l = 0;
    while (r > 2) begin
      r = 2 * (r / 3) + r % 3;
      l++;
    end
    return l;
  endfunction

  localparam int LAYERS = layer_count(OP_NUM);

  // Row l holds the operands that enter layer l, row LAYERS holds the result
  logic [OP_WIDTH-1:0] row [LAYERS+1][OP_NUM];

  for (genvar k = 0; k < OP_NUM; k++) begin : g_in
    assign row[0][k] = in_op[k];
  end

  for (genvar l = 0; l < LAYERS; l++) begin : g_layer
    localparam int CUR = rows_after(OP_NUM, l);
    localparam int GRP = CUR / 3;
    localparam int NXT = 2 * GRP + CUR % 3;

    // Each group of three rows becomes a sum row and a carry row
    for (genvar j = 0; j < GRP; j++) begin : g_csa
      logic [OP_WIDTH-1:0] a;
      logic [OP_WIDTH-1:0] b;
      logic [OP_WIDTH-1:0] c;
      assign a = row[l][3*j];
      assign b = row[l][3*j+1];
      assign c = row[l][3*j+2];
      assign row[l+1][2*j]   = a ^ b ^ c;
      // The carry has double weight, and its top bit falls off modulo 2^OP_WIDTH
      assign row[l+1][2*j+1] = ((a & b) | (a & c) | (b & c)) << 1;
    end

    // Rows that do not fill a group skip this layer unchanged
    for (genvar k = 0; k < CUR % 3; k++) begin : g_pass
      assign row[l+1][2*GRP+k] = row[l][3*GRP+k];
    end

    // Slots above the live rows stay at zero
    for (genvar k = NXT; k < OP_NUM; k++) begin : g_pad
      assign row[l+1][k] = '0;
    end
  end

  assign out_op[0] = row[LAYERS][0];
  assign out_op[1] = row[LAYERS][1];

endmodule

`default_nettype wire

// ==== booth4_op_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module booth4_op_generator (
  input  logic [mul_pkg::MUL_SIZE-1:0]  in_op1,
  input  logic [mul_pkg::MUL_SIZE-1:0]  in_op2,
  input  logic                          in_op1_signed,
  input  logic                          in_op2_signed,
  output logic [mul_pkg::PROD_SIZE-1:0] out_op [mul_pkg::PP_NUM]
);

  import mul_pkg::*;

  // Map one 3-bit multiplier window to its Booth selection
  function automatic booth_sel_e booth_decode(input logic [2:0] window);
    case (window)
      3'b001, 3'b010: return BOOTH_POS1;
      3'b011:         return BOOTH_POS2;
      3'b100:         return BOOTH_NEG2;
      3'b101, 3'b110: return BOOTH_NEG1;
      default:        return BOOTH_ZERO;
    endcase
  endfunction

  // Negative selections use the plain inverse, the missing +1 is added elsewhere
  function automatic logic [PROD_SIZE-1:0] booth_pp(input booth_sel_e sel,
                                                    input logic [PROD_SIZE-1:0] base);
    case (sel)
      BOOTH_POS1: return base;
      BOOTH_POS2: return base << 1;
      BOOTH_NEG2: return ~(base << 1);
      BOOTH_NEG1: return ~base;
      default:    return '0;
    endcase
  endfunction

  logic                     multiplicand_sign;
  logic                     multiplier_sign;
  logic [MUL_SIZE+2:0]      multiplier_ext;
  logic [PROD_SIZE-1:0]     multiplicand_ext;
  booth_sel_e               booth_sel   [OP_NUM];
  logic [NEG_CNT_WIDTH-1:0] neg_flag_op [OP_NUM];
  logic [NEG_CNT_WIDTH-1:0] neg_cnt     [2];

  // An unsigned operand simply extends with zeros
  assign multiplicand_sign = in_op1_signed & in_op1[MUL_SIZE-1];
  assign multiplier_sign   = in_op2_signed & in_op2[MUL_SIZE-1];

  // Two sign bits on top and an implicit zero below bit 0
  assign multiplier_ext   = {{2{multiplier_sign}}, in_op2, 1'b0};
  assign multiplicand_ext = {{(PROD_SIZE-MUL_SIZE){multiplicand_sign}}, in_op1};

  for (genvar i = 0; i < OP_NUM; i++) begin : g_pp
    assign booth_sel[i] = booth_decode(multiplier_ext[2*i+2 -: 3]);
    // Window i carries weight 4^i
    assign out_op[i]    = booth_pp(booth_sel[i], multiplicand_ext << (2 * i));
    // A one-valued row for every window that needs a +1
    assign neg_flag_op[i] = NEG_CNT_WIDTH'(booth_sel[i] == BOOTH_NEG1 ||
                                           booth_sel[i] == BOOTH_NEG2);
  end

  // Sum the +1 terms in a small tree instead of a wide adder
  op_n_to_2_nbit #(
    .OP_NUM   (OP_NUM),
    .OP_WIDTH (NEG_CNT_WIDTH)
  ) u_neg_cnt_tree (
    .in_op  (neg_flag_op),
    .out_op (neg_cnt)
  );

  assign out_op[OP_NUM]   = PROD_SIZE'(neg_cnt[0]);
  assign out_op[OP_NUM+1] = PROD_SIZE'(neg_cnt[1]);

  // With an unsigned multiplier the top window sees 00x and can never subtract
  always_comb begin
    if (!in_op2_signed) begin
      assert (booth_sel[OP_NUM-1] != BOOTH_NEG1 && booth_sel[OP_NUM-1] != BOOTH_NEG2)
        else $error("top Booth window selected a negative row for an unsigned multiplier");
    end
  end

endmodule

`default_nettype wire

// ==== mul_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_pipe (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_valid,
  input  flow_pkg::mul_req_t  req,
  output logic                s3_valid,
  output flow_pkg::mul_resp_t s3_resp
);

  import mul_pkg::*;
  import flow_pkg::*;

  // What stage 2 hands to the final adder
  typedef struct packed {
    mul_op_e              op;
    logic [TAG_WIDTH-1:0] tag;
    logic [PROD_SIZE-1:0] sum;
    logic [PROD_SIZE-1:0] carry;
  } s2_data_t;

  logic                 s1_valid;
  mul_req_t             s1_req;
  logic                 op1_signed;
  logic                 op2_signed;
  logic [PROD_SIZE-1:0] pp      [PP_NUM];
  logic [PROD_SIZE-1:0] pp_pair [2];
  logic                 s2_valid;
  s2_data_t             s2_data;
  logic [PROD_SIZE-1:0] product;
  logic [MUL_SIZE-1:0]  result;

  // The low half is the same for any signedness, so OP_MUL reuses the signed path
  always_comb begin
    unique case (s1_req.op)
      OP_MUL, OP_MULH: {op1_signed, op2_signed} = 2'b11;
      OP_MULHSU:       {op1_signed, op2_signed} = 2'b10;
      default:         {op1_signed, op2_signed} = 2'b00;
    endcase
  end

  booth4_op_generator u_booth (
    .in_op1        (s1_req.op1),
    .in_op2        (s1_req.op2),
    .in_op1_signed (op1_signed),
    .in_op2_signed (op2_signed),
    .out_op        (pp)
  );

  // All 19 rows collapse to one sum and carry pair in the same cycle
  op_n_to_2_nbit #(
    .OP_NUM   (PP_NUM),
    .OP_WIDTH (PROD_SIZE)
  ) u_pp_tree (
    .in_op  (pp),
    .out_op (pp_pair)
  );

  // Only one carry-propagate add in the whole datapath
  assign product = s2_data.sum + s2_data.carry;
  assign result  = (s2_data.op == OP_MUL) ? product[MUL_SIZE-1:0]
                                          : product[PROD_SIZE-1:MUL_SIZE];

  // Valid bits move every cycle, the pipeline never stalls
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      s1_valid <= req_valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  // Payload only loads behind a valid bit
  always_ff @(posedge clk) begin
    if (req_valid) s1_req <= req;
    if (s1_valid) begin
      s2_data.op    <= s1_req.op;
      s2_data.tag   <= s1_req.tag;
      s2_data.sum   <= pp_pair[0];
      s2_data.carry <= pp_pair[1];
    end
    if (s2_valid) begin
      s3_resp.tag    <= s2_data.tag;
      s3_resp.result <= result;
    end
  end

endmodule

`default_nettype wire

// ==== credit_resp_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_resp_buffer (
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  input  flow_pkg::mul_resp_t in_resp,
  input  logic                resp_credit,
  output logic                resp_valid,
  output flow_pkg::mul_resp_t resp,
  output logic                req_credit
);

  import flow_pkg::*;

  mul_resp_t                      mem [BUF_DEPTH];
  logic [$clog2(BUF_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(BUF_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(BUF_DEPTH+1)-1:0] count;
  logic [CREDIT_WIDTH-1:0]        credit_cnt;
  logic                           send;

  // A response leaves when one is buffered and the consumer has room for it
  assign send       = (count != '0) && (credit_cnt != '0);
  assign resp_valid = send;
  assign resp       = mem[rd_ptr];
  // The freed entry goes straight back to the producer as a credit
  assign req_credit = send;

  // Write port of the response storage
  always_ff @(posedge clk) begin
    if (in_valid) mem[wr_ptr] <= in_resp;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_cnt <= CREDIT_WIDTH'(RESP_CREDITS);
    end else begin
      if (in_valid) wr_ptr <= (wr_ptr == BUF_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (send) rd_ptr <= (rd_ptr == BUF_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      count <= count + ($bits(count))'(in_valid) - ($bits(count))'(send);
      // Spend one credit per response and regain one per returned pulse
      credit_cnt <= credit_cnt + CREDIT_WIDTH'(resp_credit) - CREDIT_WIDTH'(send);
    end
  end

  // The upstream credit pool must keep the pipeline from landing on a full FIFO
  a_no_write_full: assert property (@(posedge clk) disable iff (reset)
    in_valid |-> (count < BUF_DEPTH))
    else $error("response FIFO written while full");

  // The consumer can never hand back more credits than it was given
  a_credit_max: assert property (@(posedge clk) disable iff (reset)
    credit_cnt <= RESP_CREDITS)
    else $error("downstream credit counter above its initial grant");

  a_no_extra_credit: assert property (@(posedge clk) disable iff (reset)
    resp_credit |-> (credit_cnt != RESP_CREDITS))
    else $error("credit returned while the counter holds every credit");

endmodule

`default_nettype wire

// ==== mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_valid,
  input  flow_pkg::mul_req_t  req,
  output logic                req_credit,
  output logic                resp_valid,
  output flow_pkg::mul_resp_t resp,
  input  logic                resp_credit
);

  import flow_pkg::*;

  // Results leave the pipeline three cycles after the request is taken
  logic      s3_valid;
  mul_resp_t s3_resp;

  mul_pipe u_pipe (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .s3_valid  (s3_valid),
    .s3_resp   (s3_resp)
  );

  // The buffer absorbs results while the consumer withholds credits
  credit_resp_buffer u_resp_buf (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (s3_valid),
    .in_resp     (s3_resp),
    .resp_credit (resp_credit),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .req_credit  (req_credit)
  );

endmodule

`default_nettype wire

// ==== mul_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit_tb;

  import mul_pkg::*;
  import flow_pkg::*;

  localparam int NUM_REQ     = 400;
  localparam int CYCLE_LIMIT = NUM_REQ * 8 + 200;

  logic      clk;
  logic      reset;
  logic      req_valid;
  mul_req_t  req;
  logic      req_credit;
  logic      resp_valid;
  mul_resp_t resp;
  logic      resp_credit;

  integer    seed = 32'hca50f0a2;
  int        cycle_cnt;
  int        issued;
  int        received;
  int        up_credits;
  int        dn_credits;
  logic      started;
  int        value_errors;
  int        protocol_errors;
  mul_resp_t exp_q [$];
  mul_resp_t exp_head;
  int        exp_count;

  mul_unit dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req         (req),
    .req_credit  (req_credit),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .resp_credit (resp_credit)
  );

  always #5 clk = ~clk;

  // Random operand with a fair share of corner values
  function automatic logic [MUL_SIZE-1:0] pick_operand();
    logic [31:0] r;
    r = $random(seed);
    case (r[3:0])
      4'd0:    return '0;
      4'd1:    return 32'd1;
      4'd2:    return '1;
      4'd3:    return 32'h80000000;
      4'd4:    return 32'h7fffffff;
      default: return $random(seed);
    endcase
  endfunction

  // Exact product of the extended operands, then the half the opcode asks for
  function automatic logic [MUL_SIZE-1:0] expected_result(input mul_op_e op,
                                                          input logic [MUL_SIZE-1:0] a,
                                                          input logic [MUL_SIZE-1:0] b);
    logic                 a_signed;
    logic                 b_signed;
    logic [PROD_SIZE-1:0] a_ext;
    logic [PROD_SIZE-1:0] b_ext;
    logic [PROD_SIZE-1:0] prod;
    case (op)
      OP_MULHSU: {a_signed, b_signed} = 2'b10;
      OP_MULHU:  {a_signed, b_signed} = 2'b00;
      default:   {a_signed, b_signed} = 2'b11;
    endcase
    a_ext = {{MUL_SIZE{a_signed & a[MUL_SIZE-1]}}, a};
    b_ext = {{MUL_SIZE{b_signed & b[MUL_SIZE-1]}}, b};
    // Both operands fit in 64 bits, so the product modulo 2^64 is exact
    prod = a_ext * b_ext;
    return (op == OP_MUL) ? prod[MUL_SIZE-1:0] : prod[PROD_SIZE-1:MUL_SIZE];
  endfunction

  // Producer, consumer and scoreboard share one clocked block
  always @(posedge clk) begin
    int          next_up;
    int          next_dn;
    logic        withhold;
    logic [31:0] rnd;
    mul_req_t    r;
    mul_resp_t   e;
    cycle_cnt <= cycle_cnt + 1;
    if (!reset) begin
      // The response seen in this cycle has been checked against the head
      if (resp_valid) begin
        void'(exp_q.pop_front());
        received <= received + 1;
      end
      // Credits held at the start of the next cycle
      next_up = up_credits - int'(req_valid) + int'(req_credit);
      up_credits <= next_up;
      if (next_up > 0 && issued < NUM_REQ) begin
        rnd    = $random(seed);
        r.op   = mul_op_e'(rnd[1:0]);
        r.tag  = TAG_WIDTH'(issued);
        r.op1  = pick_operand();
        r.op2  = pick_operand();
        e.tag    = r.tag;
        e.result = expected_result(r.op, r.op1, r.op2);
        exp_q.push_back(e);
        req       <= r;
        req_valid <= 1'b1;
        issued    <= issued + 1;
        started   <= 1'b1;
      end else begin
        req_valid <= 1'b0;
      end
      // Downstream credits the unit still holds after this cycle
      next_dn = dn_credits - int'(resp_valid) + int'(resp_credit);
      dn_credits <= next_dn;
      // Alternate 64-cycle phases of stingy and prompt credit return
      withhold = cycle_cnt[6] && (issued < NUM_REQ);
      rnd = $random(seed);
      if (next_dn < RESP_CREDITS && (!withhold || rnd[2:0] == 3'd0))
        resp_credit <= 1'b1;
      else
        resp_credit <= 1'b0;
      exp_count <= exp_q.size();
      if (exp_q.size() != 0) exp_head <= exp_q[0];
    end
  end

  a_quiet_before_first: assert property (@(posedge clk) disable iff (reset)
    !started |-> (!resp_valid && !req_credit))
    else begin
      protocol_errors++;
      $display("resp_valid or req_credit went high before any request at %0t", $time);
    end

  a_resp_expected: assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> (exp_count != 0))
    else begin
      protocol_errors++;
      $display("a response arrived with nothing outstanding at %0t", $time);
    end

  a_resp_tag: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && exp_count != 0) |-> (resp.tag == exp_head.tag))
    else begin
      value_errors++;
      $display("error at %0t: resp.tag = %h, expected %h",
               $time, $sampled(resp.tag), $sampled(exp_head.tag));
    end

  a_resp_result: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && exp_count != 0) |-> (resp.result == exp_head.result))
    else begin
      value_errors++;
      $display("error at %0t: resp.result = %h, expected %h",
               $time, $sampled(resp.result), $sampled(exp_head.result));
    end

  // The unit may only send against a credit the consumer has granted
  a_resp_has_credit: assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> (dn_credits != 0))
    else begin
      protocol_errors++;
      $display("resp_valid high with no downstream credit at %0t", $time);
    end

  a_credit_per_resp: assert property (@(posedge clk) disable iff (reset)
    req_credit == resp_valid)
    else begin
      protocol_errors++;
      $display("req_credit pulse does not match a received response at %0t", $time);
    end

  a_up_credit_range: assert property (@(posedge clk) disable iff (reset)
    (up_credits >= 0) && (up_credits <= BUF_DEPTH) && (!req_valid || up_credits > 0))
    else begin
      protocol_errors++;
      $display("producer credit count %0d left its legal range at %0t",
               $sampled(up_credits), $time);
    end

  initial begin
    clk             = 1'b0;
    reset           = 1'b1;
    req_valid       = 1'b0;
    req             = '0;
    resp_credit     = 1'b0;
    cycle_cnt       = 0;
    issued          = 0;
    received        = 0;
    up_credits      = BUF_DEPTH;
    dn_credits      = RESP_CREDITS;
    started         = 1'b0;
    value_errors    = 0;
    protocol_errors = 0;
    exp_head        = '0;
    exp_count       = 0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    // Run until every request is answered or the cycle budget is spent
    while ((issued < NUM_REQ || exp_count != 0) && cycle_cnt < CYCLE_LIMIT)
      @(posedge clk);
    if (cycle_cnt >= CYCLE_LIMIT) begin
      protocol_errors++;
      $display("timeout after %0d cycles with %0d requests issued", cycle_cnt, issued);
    end
    // A few idle cycles catch any response that should not exist
    repeat (4) @(posedge clk);
    if (exp_count != 0) begin
      protocol_errors++;
      $display("%0d expected responses never arrived", exp_count);
    end
    $display("requests %0d, responses %0d, value errors %0d, protocol errors %0d",
             issued, received, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mul_unit.f ====
mul_pkg.sv
flow_pkg.sv
op_n_to_2_nbit.sv
booth4_op_generator.sv
mul_pipe.sv
credit_resp_buffer.sv
mul_unit.sv
mul_unit_tb.sv

// ==== Makefile ====
TOP = mul_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f mul_unit.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only -Wall -f mul_unit.f --top-module $(TOP) --timing

clean:
	rm -rf obj_dir sim.log
